/* hw/fc_irq_pkg.sv */
// **********************************************************
// fabric controller interrupt definitions
// line count, id widths, fast-line remap constants and the
// request / acknowledge structs shared along the irq path
// **********************************************************

package fc_irq_pkg;

    // **********************************************************
    // widths
    // **********************************************************
    localparam int NB_IRQ      = 32;  // event lines into the controller
    localparam int NB_FAST_IRQ = 15;  // fast lines on the ibex side

    typedef logic [4:0]        irq_id_t;   // full interrupt id
    typedef logic [3:0]        fast_id_t;  // fast-line index
    typedef logic [NB_IRQ-1:0] irq_vec_t;  // one bit per line

    // **********************************************************
    // soc event fifo remap
    // **********************************************************
    localparam irq_id_t  FIFO_IRQ_ID    = 5'd26;
    localparam fast_id_t FIFO_FAST_LINE = 4'd10;  // carries id 26 to the core

    // selected request towards the core
    typedef struct packed {
        logic    req;
        irq_id_t id;
    } irq_req_t;

    // acknowledge coming back, already remapped to a full id
    typedef struct packed {
        logic    ack;
        irq_id_t id;
    } irq_ack_t;

endpackage

/* hw/fc_irq_top.sv */
// **********************************************************
// fabric controller interrupt path
// event lines and soc event fifo into pending cells, priority
// selection and remap onto the ibex fast interrupt lines
// **********************************************************

module fc_irq_top #(
    parameter int EVT_FIFO_DEPTH = soc_event_pkg::EVT_FIFO_DEPTH_DEF
) (
    input  logic                               clk_i,
    input  logic                               rst_i,

    input  fc_irq_pkg::irq_vec_t               events_i,
    input  fc_irq_pkg::irq_vec_t               irq_mask_i,

    // soc event input
    input  logic                               evt_valid_i,
    input  soc_event_pkg::event_id_t           evt_data_i,
    output logic                               evt_ready_o,
    output soc_event_pkg::event_id_t           evt_head_o,

    // core side
    output logic [fc_irq_pkg::NB_FAST_IRQ-1:0] irq_fast_o,
    input  logic                               irq_ack_i,
    input  fc_irq_pkg::fast_id_t               irq_ack_fast_id_i
);

    import fc_irq_pkg::*;

    logic     evt_avail;
    logic     evt_pop;
    irq_vec_t src_vec;
    irq_vec_t clr_vec;
    irq_vec_t pending_vec;
    irq_req_t irq_req;
    irq_ack_t irq_ack;

    // **********************************************************
    // soc event fifo
    // **********************************************************
    soc_event_fifo #(
        .EVT_FIFO_DEPTH ( EVT_FIFO_DEPTH )
    ) u_evt_fifo (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .evt_valid_i ( evt_valid_i ),
        .evt_data_i  ( evt_data_i  ),
        .evt_ready_o ( evt_ready_o ),
        .pop_i       ( evt_pop     ),
        .evt_head_o  ( evt_head_o  ),
        .evt_avail_o ( evt_avail   )
    );

    irq_source_mux u_src_mux (
        .events_i    ( events_i  ),
        .evt_avail_i ( evt_avail ),
        .ack_i       ( irq_ack   ),
        .src_o       ( src_vec   ),
        .clr_o       ( clr_vec   ),
        .pop_o       ( evt_pop   )
    );

    // **********************************************************
    // pending array
    // **********************************************************
    for (genvar k = 0; k < NB_IRQ; k++) begin : gen_pending
        irq_pending_cell u_cell (
            .clk_i     ( clk_i          ),
            .rst_i     ( rst_i          ),
            .src_i     ( src_vec[k]     ),
            .clr_i     ( clr_vec[k]     ),
            .pending_o ( pending_vec[k] )
        );
    end

    // **********************************************************
    // selection and remap, combinational to the core
    // **********************************************************
    irq_priority_sel u_prio_sel (
        .pending_i ( pending_vec ),
        .mask_i    ( irq_mask_i  ),
        .req_o     ( irq_req     )
    );

    irq_fast_remap u_fast_remap (
        .req_i             ( irq_req           ),
        .irq_fast_o        ( irq_fast_o        ),
        .irq_ack_i         ( irq_ack_i         ),
        .irq_ack_fast_id_i ( irq_ack_fast_id_i ),
        .ack_o             ( irq_ack           )
    );

endmodule

/* hw/irq_fast_remap.sv */
// **********************************************************
// irq fast remap
// request id to ibex fast lines, fast ack index back to an id
// id 26 (event fifo) travels on fast line 10
// **********************************************************

module irq_fast_remap (
    input  fc_irq_pkg::irq_req_t                  req_i,
    output logic [fc_irq_pkg::NB_FAST_IRQ-1:0]    irq_fast_o,

    input  logic                                  irq_ack_i,
    input  fc_irq_pkg::fast_id_t                  irq_ack_fast_id_i,
    output fc_irq_pkg::irq_ack_t                  ack_o
);

    import fc_irq_pkg::*;

    // **********************************************************
    // id to fast line
    // **********************************************************
    always_comb begin
        irq_fast_o = '0;
        if (req_i.req) begin
            if (req_i.id == FIFO_IRQ_ID) begin
                irq_fast_o[FIFO_FAST_LINE] = 1'b1;
            end else if (req_i.id < irq_id_t'(NB_FAST_IRQ)) begin
                irq_fast_o[fast_id_t'(req_i.id)] = 1'b1;
            end
            // ids 15..31 other than 26 have no fast line
        end
    end

    // **********************************************************
    // fast ack to id
    // **********************************************************
    always_comb begin
        ack_o.ack = irq_ack_i;
        if (irq_ack_fast_id_i == FIFO_FAST_LINE) begin
            ack_o.id = FIFO_IRQ_ID;
        end else begin
            ack_o.id = {1'b0, irq_ack_fast_id_i};
        end
    end

endmodule

/* hw/irq_pending_cell.sv */
// **********************************************************
// irq pending cell
// one sticky pending flag, set wins over clear
// **********************************************************

module irq_pending_cell (
    input  logic clk_i,
    input  logic rst_i,

    input  logic src_i,
    input  logic clr_i,
    output logic pending_o
);

    logic pending_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
        end else if (src_i) begin
            pending_q <= 1'b1;  // new event beats a same-cycle ack
        end else if (clr_i) begin
            pending_q <= 1'b0;
        end
    end

    assign pending_o = pending_q;

endmodule

/* hw/irq_priority_sel.sv */
// **********************************************************
// irq priority selector
// masks the pending lines and picks the lowest index
// **********************************************************

module irq_priority_sel (
    input  fc_irq_pkg::irq_vec_t pending_i,
    input  fc_irq_pkg::irq_vec_t mask_i,
    output fc_irq_pkg::irq_req_t req_o
);

    import fc_irq_pkg::*;

    irq_vec_t active;

    assign active = pending_i & mask_i;  // mask bit high enables the line

    // **********************************************************
    // lowest set bit
    // **********************************************************
    // scan from the top so the last hit is the lowest line
    always_comb begin
        req_o = '0;
        for (int i = NB_IRQ - 1; i >= 0; i--) begin
            if (active[i]) begin
                req_o.req = 1'b1;
                req_o.id  = irq_id_t'(i);
            end
        end
    end

endmodule

/* hw/irq_source_mux.sv */
// **********************************************************
// irq source mux
// builds the 32 set lines, with the event fifo on line 26,
// and decodes the acknowledge id into one-hot clears
// **********************************************************

module irq_source_mux (
    input  fc_irq_pkg::irq_vec_t events_i,
    input  logic                 evt_avail_i,
    input  fc_irq_pkg::irq_ack_t ack_i,

    output fc_irq_pkg::irq_vec_t src_o,
    output fc_irq_pkg::irq_vec_t clr_o,
    output logic                 pop_o
);

    import fc_irq_pkg::*;

    // **********************************************************
    // set side
    // **********************************************************
    always_comb begin
        src_o = events_i;
        // line 26 belongs to the fifo, the raw event is dropped
        src_o[FIFO_IRQ_ID] = evt_avail_i;
    end

    // **********************************************************
    // clear side
    // **********************************************************
    always_comb begin
        clr_o = '0;
        if (ack_i.ack) begin
            clr_o[ack_i.id] = 1'b1;
        end
    end

    // ack of id 26 consumes the fifo head
    assign pop_o = clr_o[FIFO_IRQ_ID];

endmodule

/* hw/soc_event_fifo.sv */
// **********************************************************
// soc event fifo
// circular buffer of event ids, valid/ready on the push side,
// head entry always visible, popped by the irq acknowledge
// **********************************************************

module soc_event_fifo #(
    parameter int EVT_FIFO_DEPTH = soc_event_pkg::EVT_FIFO_DEPTH_DEF
) (
    input  logic                     clk_i,
    input  logic                     rst_i,

    input  logic                     evt_valid_i,
    input  soc_event_pkg::event_id_t evt_data_i,
    output logic                     evt_ready_o,

    input  logic                     pop_i,
    output soc_event_pkg::event_id_t evt_head_o,
    output logic                     evt_avail_o
);

    import soc_event_pkg::*;

    localparam int PTR_W = $clog2(EVT_FIFO_DEPTH);
    localparam int CNT_W = $clog2(EVT_FIFO_DEPTH + 1);

    event_id_t        mem_q [EVT_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic full;
    logic empty;
    logic push;
    logic pop;

    // wrap at depth, not at a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(EVT_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count_q == CNT_W'(EVT_FIFO_DEPTH));
    assign empty = (count_q == '0);

    assign evt_ready_o = ~full;
    assign push        = evt_valid_i & ~full;
    assign pop         = pop_i & ~empty;  // ignore pops on empty

    assign evt_head_o  = mem_q[rd_ptr_q];

    // an entry survives this cycle's pop
    assign evt_avail_o = (count_q > CNT_W'(1)) || ((count_q == CNT_W'(1)) && !pop_i);

    // **********************************************************
    // storage
    // **********************************************************
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= evt_data_i;
        end
    end

    // **********************************************************
    // pointers and fill level
    // **********************************************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or none
            endcase
        end
    end

endmodule

/* hw/soc_event_pkg.sv */
// **********************************************************
// soc event definitions
// event id type and event fifo defaults
// **********************************************************

package soc_event_pkg;

    // id carried by one soc event
    typedef logic [7:0] event_id_t;

    // default fifo depth, top level may override
    localparam int EVT_FIFO_DEPTH_DEF = 4;

endpackage

/* project.f */
hw/fc_irq_pkg.sv
hw/soc_event_pkg.sv
hw/soc_event_fifo.sv
hw/irq_source_mux.sv
hw/irq_pending_cell.sv
hw/irq_priority_sel.sv
hw/irq_fast_remap.sv
hw/fc_irq_top.sv
verif/tb_fc_irq.sv

/* verif/tb_fc_irq.sv */
// **********************************************************
// testbench for the fabric controller interrupt path
// reference model of pending lines and event fifo with
// concurrent assertions comparing the DUT against it
// **********************************************************

module tb_fc_irq;

    import fc_irq_pkg::*;
    import soc_event_pkg::*;

    localparam int          EVT_FIFO_DEPTH = EVT_FIFO_DEPTH_DEF;
    localparam int          CLK_PERIOD     = 20;
    localparam logic [31:0] RNG_SEED       = 32'h1d7;
    localparam irq_vec_t    BASE_MASK      = 32'h0400_7bff;  // lines 0..14 without 10 and with 26
    localparam int          WAIT_LIMIT     = 20;             // cycles per handshake wait

    localparam int N_SINGLE       = 6;  // single-line pulses in test 2
    localparam int N_PUSH         = 3;  // fifo entries in test 4
    localparam int CYCLES_PER_IRQ = 10;

    // watchdog budget from the test lengths
    localparam int WATCHDOG_CYCLES = 2 + 5
                                   + N_SINGLE * CYCLES_PER_IRQ
                                   + 5 * CYCLES_PER_IRQ
                                   + 2 * N_PUSH * CYCLES_PER_IRQ
                                   + (2 * EVT_FIFO_DEPTH + 2) * CYCLES_PER_IRQ
                                   + 200;

    logic                   clk_i = 1'b0;
    logic                   rst_i;
    irq_vec_t               events_i;
    irq_vec_t               irq_mask_i;
    logic                   evt_valid_i;
    event_id_t              evt_data_i;
    logic                   evt_ready_o;
    event_id_t              evt_head_o;
    logic [NB_FAST_IRQ-1:0] irq_fast_o;
    logic                   irq_ack_i;
    fast_id_t               irq_ack_fast_id_i;

    int errors         = 0;
    int errors_at_test = 0;
    int tests_run      = 0;

    // reference model state
    event_id_t              model_q[$];
    irq_vec_t               pending_m;
    int                     exp_count = 0;
    event_id_t              exp_head;
    logic [NB_FAST_IRQ-1:0] exp_fast;
    logic [NB_FAST_IRQ-1:0] fast_mask;

    fc_irq_top #(
        .EVT_FIFO_DEPTH ( EVT_FIFO_DEPTH )
    ) DUT (
        .clk_i             ( clk_i             ),
        .rst_i             ( rst_i             ),
        .events_i          ( events_i          ),
        .irq_mask_i        ( irq_mask_i        ),
        .evt_valid_i       ( evt_valid_i       ),
        .evt_data_i        ( evt_data_i        ),
        .evt_ready_o       ( evt_ready_o       ),
        .evt_head_o        ( evt_head_o        ),
        .irq_fast_o        ( irq_fast_o        ),
        .irq_ack_i         ( irq_ack_i         ),
        .irq_ack_fast_id_i ( irq_ack_fast_id_i )
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // **********************************************************
    // reference model
    // **********************************************************
    // fast ack index 10 maps to the fifo id and others zero extend
    function automatic irq_id_t ack_to_id(input fast_id_t fid);
        if (fid == FIFO_FAST_LINE) begin
            return FIFO_IRQ_ID;
        end
        return irq_id_t'(fid);
    endfunction

    always @(posedge clk_i) begin : model_update
        int       cnt;
        logic     ack_fifo;
        logic     avail;
        irq_vec_t src;
        irq_vec_t clr;
        if (rst_i) begin
            model_q.delete();
            pending_m <= '0;
            exp_count <= 0;
        end else begin
            cnt      = model_q.size();
            ack_fifo = irq_ack_i && (irq_ack_fast_id_i == FIFO_FAST_LINE);
            avail    = (cnt >= 2) || (cnt == 1 && !ack_fifo);  // entry left after the pop
            src      = events_i;
            src[FIFO_IRQ_ID] = avail;
            clr = '0;
            if (irq_ack_i) begin
                clr[ack_to_id(irq_ack_fast_id_i)] = 1'b1;
            end
            pending_m <= src | (pending_m & ~clr);  // set wins
            if (ack_fifo && cnt > 0) begin
                void'(model_q.pop_front());
            end
            if (evt_valid_i && cnt < EVT_FIFO_DEPTH) begin
                model_q.push_back(evt_data_i);
            end
            exp_count <= model_q.size();
            if (model_q.size() > 0) begin
                exp_head <= model_q[0];
            end
        end
    end

    // lowest unmasked pending line mapped onto the fast lines
    always_comb begin
        irq_vec_t active;
        logic     found;
        active   = pending_m & irq_mask_i;
        found    = 1'b0;
        exp_fast = '0;
        for (int i = 0; i < NB_IRQ; i++) begin
            if (!found && active[i]) begin
                found = 1'b1;
                if (i == FIFO_IRQ_ID) begin
                    exp_fast[FIFO_FAST_LINE] = 1'b1;
                end else if (i < NB_FAST_IRQ) begin
                    exp_fast[i] = 1'b1;
                end
            end
        end
    end

    // fast line 10 is enabled by mask bit 26
    assign fast_mask = {irq_mask_i[14:11], irq_mask_i[FIFO_IRQ_ID], irq_mask_i[9:0]};

    // **********************************************************
    // checks
    // **********************************************************
    reset_state: assert property (@(posedge clk_i)
        $fell(rst_i) |-> (irq_fast_o == '0 && evt_ready_o))
    else begin
        errors++;
        $display(
            "mismatch at %0t: irq_fast_o expected 0, actual %h; evt_ready_o expected 1, actual %b",
            $time, $sampled(irq_fast_o), $sampled(evt_ready_o));
    end

    fast_matches_model: assert property (@(posedge clk_i) disable iff (rst_i)
        irq_fast_o == exp_fast)
    else begin
        errors++;
        $display("mismatch at %0t: irq_fast_o expected %h, actual %h",
                 $time, $sampled(exp_fast), $sampled(irq_fast_o));
    end

    masked_never_shown: assert property (@(posedge clk_i) disable iff (rst_i)
        (irq_fast_o & ~fast_mask) == '0)
    else begin
        errors++;
        $display("mismatch at %0t: irq_fast_o masked bits expected 0, actual %h",
                 $time, $sampled(irq_fast_o & ~fast_mask));
    end

    one_line_at_most: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(irq_fast_o))
    else begin
        errors++;
        $display("more than one fast line high at %0t: %h", $time, $sampled(irq_fast_o));
    end

    ready_matches_model: assert property (@(posedge clk_i) disable iff (rst_i)
        evt_ready_o == (exp_count != EVT_FIFO_DEPTH))
    else begin
        errors++;
        $display("mismatch at %0t: evt_ready_o expected %b, actual %b",
                 $time, $sampled(exp_count != EVT_FIFO_DEPTH), $sampled(evt_ready_o));
    end

    head_matches_model: assert property (@(posedge clk_i) disable iff (rst_i)
        (exp_count != 0) |-> (evt_head_o == exp_head))
    else begin
        errors++;
        $display("mismatch at %0t: evt_head_o expected %h, actual %h",
                 $time, $sampled(exp_head), $sampled(evt_head_o));
    end

    // **********************************************************
    // stimulus helpers
    // **********************************************************
    // random line below 15 other than 10
    function automatic int pick_line();
        int line;
        line = $urandom_range(0, 13);
        if (line >= 10) begin
            line++;
        end
        return line;
    endfunction

    task automatic pulse_events(input irq_vec_t lines);
        @(posedge clk_i);
        events_i <= lines;
        @(posedge clk_i);
        events_i <= '0;
    endtask

    task automatic send_ack(input int line);
        @(posedge clk_i);
        irq_ack_i         <= 1'b1;
        irq_ack_fast_id_i <= fast_id_t'(line);
        @(posedge clk_i);
        irq_ack_i         <= 1'b0;
        irq_ack_fast_id_i <= '0;
    endtask

    task automatic wait_fast_line(input int line, input logic level);
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        while (irq_fast_o[line] !== level && cycles < WAIT_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (irq_fast_o[line] !== level) begin
            errors++;
            $display("fast line %0d did not go to %b within %0d cycles", line, level, WAIT_LIMIT);
        end
    endtask

    // holds valid and data until the fifo takes the entry
    task automatic push_event(input event_id_t data);
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        evt_valid_i <= 1'b1;
        evt_data_i  <= data;
        @(posedge clk_i);
        while (!evt_ready_o && cycles < WAIT_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!evt_ready_o) begin
            errors++;
            $display("event fifo did not accept %h within %0d cycles", data, WAIT_LIMIT);
        end
        evt_valid_i <= 1'b0;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d (%s) finished with %0d errors", tests_run, name,
                 errors - errors_at_test);
        errors_at_test = errors;
    endtask

    // **********************************************************
    // tests
    // **********************************************************
    task automatic cycle_single_lines();
        int k;
        for (int n = 0; n < N_SINGLE; n++) begin
            k = pick_line();
            pulse_events(irq_vec_t'(1) << k);
            wait_fast_line(k, 1'b1);
            send_ack(k);
            wait_fast_line(k, 1'b0);
        end
        report_test("single event lines");
    endtask

    task automatic sweep_priority_mask();
        int a;
        int b;
        int c;
        int t;
        a = pick_line();
        b = a;
        c = a;
        while (b == a) b = pick_line();
        while (c == a || c == b) c = pick_line();
        if (a > b) begin
            t = a;
            a = b;
            b = t;
        end
        @(posedge clk_i);
        irq_mask_i <= BASE_MASK & ~(irq_vec_t'(1) << c);  // c held back
        pulse_events((irq_vec_t'(1) << a) | (irq_vec_t'(1) << b) | (irq_vec_t'(1) << c));
        wait_fast_line(a, 1'b1);
        send_ack(a);
        wait_fast_line(b, 1'b1);
        send_ack(b);
        wait_fast_line(b, 1'b0);
        repeat (3) @(posedge clk_i);
        irq_mask_i <= BASE_MASK;
        wait_fast_line(c, 1'b1);
        send_ack(c);
        wait_fast_line(c, 1'b0);
        report_test("priority and mask");
    endtask

    task automatic drain_fifo_in_order();
        for (int n = 0; n < N_PUSH; n++) begin
            push_event(event_id_t'($urandom_range(0, 255)));
        end
        for (int n = 0; n < N_PUSH; n++) begin
            wait_fast_line(FIFO_FAST_LINE, 1'b1);
            send_ack(FIFO_FAST_LINE);
        end
        wait_fast_line(FIFO_FAST_LINE, 1'b0);
        report_test("event fifo order");
    endtask

    task automatic overfill_fifo();
        for (int n = 0; n < EVT_FIFO_DEPTH; n++) begin
            push_event(event_id_t'($urandom_range(0, 255)));
        end
        fork
            push_event(event_id_t'($urandom_range(0, 255)));  // stalls while full
            begin
                repeat (4) @(posedge clk_i);
                send_ack(FIFO_FAST_LINE);
            end
        join
        for (int n = 0; n < EVT_FIFO_DEPTH; n++) begin
            wait_fast_line(FIFO_FAST_LINE, 1'b1);
            send_ack(FIFO_FAST_LINE);
        end
        wait_fast_line(FIFO_FAST_LINE, 1'b0);
        report_test("event fifo back-pressure");
    endtask

    // **********************************************************
    // main sequence and watchdog
    // **********************************************************
    initial begin
        rst_i             = 1'b1;
        events_i          = '0;
        irq_mask_i        = BASE_MASK;
        evt_valid_i       = 1'b0;
        evt_data_i        = '0;
        irq_ack_i         = 1'b0;
        irq_ack_fast_id_i = '0;
        void'($urandom(RNG_SEED));

        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        repeat (3) @(posedge clk_i);
        report_test("reset state");

        cycle_single_lines();
        sweep_priority_mask();
        drain_fifo_in_order();
        overfill_fifo();

        repeat (3) @(posedge clk_i);  // let the last checks fire
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("the run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule
